//--- hw/vid_pkg.sv
// Video colour stage shared types

`default_nettype none

package vid_pkg;

    // Palette address width
    localparam int LUT_AW = 8;

    // Palette select for the two playfields
    typedef enum logic {
        LUT_A = 1'b0,
        LUT_B = 1'b1
    } lut_sel_e;

    // Arithmetic operations selected by B when ext is set
    typedef enum logic [1:0] {
        OP_ADD_WRAP  = 2'd0,
        OP_SUB_WRAP  = 2'd1,
        OP_ADD_CLAMP = 2'd2,
        OP_SUB_CLAMP = 2'd3
    } blend_op_e;

    // Alpha levels of B over A
    localparam logic [1:0] ALPHA_A    = 2'd0;
    localparam logic [1:0] ALPHA_3A1B = 2'd1;
    localparam logic [1:0] ALPHA_HALF = 2'd2;
    localparam logic [1:0] ALPHA_B    = 2'd3;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic [1:0] alpha;
        logic       mix;
        logic       ext;
        rgb_t       rgb;
    } argb_alpha_t;

    typedef struct packed {
        blend_op_e  op;
        logic       mix;
        logic       ext;
        rgb_t       rgb;
    } argb_op_t;

    // Top two bits read as alpha or op depending on ext
    typedef union packed {
        argb_alpha_t blend;
        argb_op_t    arith;
    } argb_t;

endpackage

`default_nettype wire

//--- hw/lut_wr_if.sv
// Palette write bus

`default_nettype none

interface lut_wr_if import vid_pkg::*; ();

    logic              we;
    lut_sel_e          sel;
    logic [LUT_AW-1:0] addr;
    argb_t             data;

    // Write port side
    modport master (
        output we,
        output sel,
        output addr,
        output data
    );

    // Palette side
    modport slave (
        input we,
        input sel,
        input addr,
        input data
    );

endinterface

`default_nettype wire

//--- hw/lut_write_port.sv
// Palette write handshake port

`default_nettype none

module lut_write_port import vid_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              req_i,
    output      logic              ack_o,
    input  wire lut_sel_e          sel_i,
    input  wire logic [LUT_AW-1:0] addr_i,
    input  wire argb_t             data_i,
    lut_wr_if.master               wr
);

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_ACKED = 1'b1
    } wp_state_e;

    wp_state_e         state;
    logic              we_q;
    lut_sel_e          sel_q;
    logic [LUT_AW-1:0] addr_q;
    argb_t             data_q;
    logic              accept;

    // New request only taken once ack has dropped
    assign accept = (state == ST_IDLE) && req_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
            we_q  <= 1'b0;
        end else begin
            we_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        state <= ST_ACKED;
                        we_q  <= 1'b1;
                    end
                end
                ST_ACKED: begin
                    // Hold ack until host releases req
                    if (!req_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Latch host fields alongside the write pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q  <= sel_i;
            addr_q <= addr_i;
            data_q <= data_i;
        end
    end

    assign ack_o   = (state == ST_ACKED);
    assign wr.we   = we_q;
    assign wr.sel  = sel_q;
    assign wr.addr = addr_q;
    assign wr.data = data_q;

endmodule

`default_nettype wire

//--- hw/color_lut.sv
// Playfield colour palette

`default_nettype none

module color_lut import vid_pkg::*; #(
    parameter lut_sel_e LUT_ID = LUT_A
) (
    input  wire logic              clk,
    lut_wr_if.slave                wr,
    input  wire logic [LUT_AW-1:0] addr_i,
    output      argb_t             color_o
);

    localparam int DEPTH = 2 ** LUT_AW;

    argb_t mem [DEPTH];
    logic  wr_hit;

    // Only writes addressed to this palette
    assign wr_hit = wr.we && (wr.sel == LUT_ID);

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        color_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- hw/video_blend.sv
// Two-playfield colour blender

`default_nettype none

module video_blend import vid_pkg::*; #(
    parameter bit EN_BLEND_MIX   = 1'b1,
    parameter bit EN_BLEND_EXTRA = 1'b1
) (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  hsync_i,
    input  wire logic  vsync_i,
    input  wire logic  dv_de_i,
    input  wire argb_t color_a_i,
    input  wire argb_t color_b_i,
    output      rgb_t  blend_rgb_o,
    output      logic  hsync_o,
    output      logic  vsync_o,
    output      logic  dv_de_o
);

    // First delay stage matches the palette read
    logic hsync_1;
    logic vsync_1;
    logic dv_de_1;

    logic      use_op;
    logic      use_mix;
    blend_op_e op;
    logic [1:0] alpha;
    rgb_t      rgb_a;
    rgb_t      rgb_b;
    rgb_t      mixed;

    // One 4-bit channel through the rule list
    function automatic logic [3:0] blend_chan(
        input logic [3:0] a,
        input logic [3:0] b,
        input logic       op_en,
        input blend_op_e  op_sel,
        input logic       mix_en,
        input logic [1:0] level
    );
        logic [4:0] sum;
        logic [4:0] diff;
        logic [5:0] sum_3a1b;
        logic [3:0] res;

        sum      = {1'b0, a} + {1'b0, b};
        diff     = {1'b0, a} - {1'b0, b};
        // 3A + B, divided by 4 below
        sum_3a1b = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};

        if (op_en) begin
            case (op_sel)
                OP_ADD_WRAP:  res = sum[3:0];
                OP_SUB_WRAP:  res = diff[3:0];
                OP_ADD_CLAMP: res = sum[4] ? 4'hF : sum[3:0];
                // Borrow out means A < B
                OP_SUB_CLAMP: res = diff[4] ? 4'h0 : diff[3:0];
                default:      res = sum[3:0];
            endcase
        end else if (mix_en) begin
            res = sum[3:0];
        end else begin
            case (level)
                ALPHA_A:    res = a;
                ALPHA_3A1B: res = sum_3a1b[5:2];
                ALPHA_HALF: res = sum[4:1];
                ALPHA_B:    res = b;
                default:    res = a;
            endcase
        end
        return res;
    endfunction

    // B's ext bit picks how its top bits decode
    assign use_op  = EN_BLEND_EXTRA && color_b_i.blend.ext;
    assign use_mix = EN_BLEND_MIX && color_a_i.blend.mix;
    assign op      = color_b_i.arith.op;
    assign alpha   = color_b_i.blend.alpha;
    assign rgb_a   = color_a_i.blend.rgb;
    assign rgb_b   = color_b_i.blend.rgb;

    always_comb begin
        mixed.r = blend_chan(rgb_a.r, rgb_b.r, use_op, op, use_mix, alpha);
        mixed.g = blend_chan(rgb_a.g, rgb_b.g, use_op, op, use_mix, alpha);
        mixed.b = blend_chan(rgb_a.b, rgb_b.b, use_op, op, use_mix, alpha);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            blend_rgb_o <= '0;
        end else if (!dv_de_1) begin
            // Blank outside the display area
            blend_rgb_o <= '0;
        end else begin
            blend_rgb_o <= mixed;
        end
    end

    // Two-stage sync delay
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            dv_de_1 <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            hsync_1 <= hsync_i;
            vsync_1 <= vsync_i;
            dv_de_1 <= dv_de_i;
            hsync_o <= hsync_1;
            vsync_o <= vsync_1;
            dv_de_o <= dv_de_1;
        end
    end

endmodule

`default_nettype wire

//--- hw/video_out_top.sv
// Video output colour stage top

`default_nettype none

module video_out_top import vid_pkg::*; #(
    parameter bit EN_BLEND_MIX   = 1'b1,
    parameter bit EN_BLEND_EXTRA = 1'b1
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    // Host palette port
    input  wire logic              lut_req_i,
    output      logic              lut_ack_o,
    input  wire logic              lut_sel_i,
    input  wire logic [LUT_AW-1:0] lut_addr_i,
    input  wire logic [15:0]       lut_data_i,
    // Playfield pixels and timing
    input  wire logic [LUT_AW-1:0] pf_a_index_i,
    input  wire logic [LUT_AW-1:0] pf_b_index_i,
    input  wire logic              hsync_i,
    input  wire logic              vsync_i,
    input  wire logic              dv_de_i,
    // Blended output
    output      logic [11:0]       blend_rgb_o,
    output      logic              hsync_o,
    output      logic              vsync_o,
    output      logic              dv_de_o
);

    argb_t color_a;
    argb_t color_b;

    lut_wr_if lut_wr ();

    lut_write_port u_wr_port (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (lut_req_i),
        .ack_o   (lut_ack_o),
        .sel_i   (lut_sel_e'(lut_sel_i)),
        .addr_i  (lut_addr_i),
        .data_i  (lut_data_i),
        .wr      (lut_wr.master)
    );

    color_lut #(
        .LUT_ID (LUT_A)
    ) u_lut_a (
        .clk     (clk),
        .wr      (lut_wr.slave),
        .addr_i  (pf_a_index_i),
        .color_o (color_a)
    );

    color_lut #(
        .LUT_ID (LUT_B)
    ) u_lut_b (
        .clk     (clk),
        .wr      (lut_wr.slave),
        .addr_i  (pf_b_index_i),
        .color_o (color_b)
    );

    video_blend #(
        .EN_BLEND_MIX   (EN_BLEND_MIX),
        .EN_BLEND_EXTRA (EN_BLEND_EXTRA)
    ) u_blend (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hsync_i     (hsync_i),
        .vsync_i     (vsync_i),
        .dv_de_i     (dv_de_i),
        .color_a_i   (color_a),
        .color_b_i   (color_b),
        .blend_rgb_o (blend_rgb_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o)
    );

endmodule

`default_nettype wire

//--- test/tb_tasks.svh
// Testbench helpers for the colour stage

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

typedef struct packed {
    rgb_t       rgb;
    logic [2:0] sync;
} exp_t;

exp_t  exp_q[$];
argb_t pal_a [256];
argb_t pal_b [256];
logic [15:0] lfsr_state = 16'd98;

// Galois LFSR, one step per bit
function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[14:0], lfsr_step()};
    end
    return v;
endfunction

// One channel through the combining rules
function automatic logic [3:0] chan_model(input logic [3:0] ca_in, input logic [3:0] cb_in,
                                          input argb_t a, input argb_t b);
    int ca;
    int cb;
    int r;
    ca = int'(ca_in);
    cb = int'(cb_in);
    if (EN_EXTRA && b.arith.ext) begin
        case (b.arith.op)
            OP_ADD_WRAP:  r = (ca + cb) % 16;
            OP_SUB_WRAP:  r = (ca - cb + 16) % 16;
            OP_ADD_CLAMP: r = (ca + cb > 15) ? 15 : ca + cb;
            default:      r = (ca < cb) ? 0 : ca - cb;
        endcase
    end else if (EN_MIX && a.blend.mix) begin
        r = (ca + cb) % 16;
    end else begin
        case (b.blend.alpha)
            2'd0:    r = ca;
            2'd1:    r = (3 * ca + cb) / 4;
            2'd2:    r = (ca + cb) / 2;
            default: r = cb;
        endcase
    end
    return r[3:0];
endfunction

function automatic rgb_t blend_model(input argb_t a, input argb_t b, input logic de);
    rgb_t res;
    res = '0;
    if (de) begin
        res.r = chan_model(a.blend.rgb.r, b.blend.rgb.r, a, b);
        res.g = chan_model(a.blend.rgb.g, b.blend.rgb.g, a, b);
        res.b = chan_model(a.blend.rgb.b, b.blend.rgb.b, a, b);
    end
    return res;
endfunction

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch %s: got 0x%03h, expected 0x%03h", name, got, exp));
    end
endtask

task automatic check_sync(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch {hsync_o,vsync_o,dv_de_o}: got 0x%h, expected 0x%h",
                           got, exp));
    end
endtask

task automatic check_ack(input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch lut_ack_o: got 0x%h, expected 0x%h", got, exp));
    end
endtask

// Four-phase palette write, shadow copy kept for the model
task automatic write_lut(input lut_sel_e sel, input logic [7:0] addr, input logic [15:0] data);
    int waits;
    @(posedge clk);
    #1;
    lut_sel  = sel;
    lut_addr = addr;
    lut_data = data;
    lut_req  = 1'b1;
    waits = 0;
    while (lut_ack !== 1'b1) begin
        if (waits == 4) begin
            fail_run("palette write: ack did not rise within 4 cycles of req");
        end
        @(posedge clk);
        #1;
        waits++;
    end
    lut_req = 1'b0;
    waits = 0;
    while (lut_ack !== 1'b0) begin
        if (waits == 4) begin
            fail_run("palette write: ack did not fall within 4 cycles of req release");
        end
        @(posedge clk);
        #1;
        waits++;
    end
    if (sel == LUT_A) begin
        pal_a[addr] = data;
    end else begin
        pal_b[addr] = data;
    end
endtask

// Check the pixel from two cycles back, then drive a new one
task automatic drive_pixel(input logic [7:0] ia, input logic [7:0] ib,
                           input logic hs, input logic vs, input logic de);
    exp_t e;
    @(posedge clk);
    #1;
    if (exp_q.size() == 2) begin
        e = exp_q.pop_front();
        check_rgb("blend_rgb_o", blend_rgb, e.rgb);
        check_sync({hsync_o, vsync_o, dv_de_o}, e.sync);
    end
    pf_a_idx = ia;
    pf_b_idx = ib;
    hsync    = hs;
    vsync    = vs;
    dv_de    = de;
    e.rgb  = blend_model(pal_a[ia], pal_b[ib], de);
    e.sync = {hs, vs, de};
    exp_q.push_back(e);
endtask

task automatic drain_pipe();
    exp_t e;
    repeat (2) begin
        @(posedge clk);
        #1;
        e = exp_q.pop_front();
        check_rgb("blend_rgb_o", blend_rgb, e.rgb);
        check_sync({hsync_o, vsync_o, dv_de_o}, e.sync);
        hsync = 1'b0;
        vsync = 1'b0;
        dv_de = 1'b0;
    end
endtask

`endif

//--- test/tb_video_out.sv
// Colour stage testbench

`default_nettype none

module tb_video_out import vid_pkg::*; ();

    localparam bit EN_MIX   = 1'b1;
    localparam bit EN_EXTRA = 1'b1;

    // Cycle budget with worst case handshake per write
    localparam int WR_MAX     = 11;
    localparam int N_WRITES   = 12 + 512;
    localparam int N_PIXELS   = 4 + 10 + 40 + 200;
    localparam int N_OVERHEAD = 6 + 4 * 2;
    localparam int TIMEOUT    = N_WRITES * WR_MAX + N_PIXELS + N_OVERHEAD + 200;

    logic        clk;
    logic        rst_n;
    logic        lut_req;
    logic        lut_ack;
    logic        lut_sel;
    logic [7:0]  lut_addr;
    logic [15:0] lut_data;
    logic [7:0]  pf_a_idx;
    logic [7:0]  pf_b_idx;
    logic        hsync;
    logic        vsync;
    logic        dv_de;
    rgb_t        blend_rgb;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;
    int          cycle_cnt;

    video_out_top #(
        .EN_BLEND_MIX   (EN_MIX),
        .EN_BLEND_EXTRA (EN_EXTRA)
    ) dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .lut_req_i    (lut_req),
        .lut_ack_o    (lut_ack),
        .lut_sel_i    (lut_sel),
        .lut_addr_i   (lut_addr),
        .lut_data_i   (lut_data),
        .pf_a_index_i (pf_a_idx),
        .pf_b_index_i (pf_b_idx),
        .hsync_i      (hsync),
        .vsync_i      (vsync),
        .dv_de_i      (dv_de),
        .blend_rgb_o  (blend_rgb),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            fail_run("timeout: tests did not finish within the cycle budget");
        end
    end

    task automatic expect_idle();
        check_ack(lut_ack, 1'b0);
        check_rgb("blend_rgb_o", blend_rgb, '0);
        check_sync({hsync_o, vsync_o, dv_de_o}, 3'b000);
    endtask

    task automatic reset_values();
        repeat (3) begin
            @(posedge clk);
            #1;
            expect_idle();
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            expect_idle();
        end
    endtask

    // Entries used by the alpha, op and mix tests
    task automatic load_entries();
        write_lut(LUT_A, 8'd1, {2'd0, 1'b0, 1'b0, 12'hF73});
        write_lut(LUT_A, 8'd2, {2'd0, 1'b0, 1'b0, 12'hC39});
        write_lut(LUT_A, 8'd3, {2'd0, 1'b1, 1'b0, 12'h9A5});
        for (int k = 0; k < 4; k++) begin
            write_lut(LUT_B, 8'(k), {2'(k), 1'b0, 1'b0, 12'h2C9});
            write_lut(LUT_B, 8'(k + 4), {2'(k), 1'b0, 1'b1, 12'h7C4});
        end
        write_lut(LUT_B, 8'd8, {2'd2, 1'b0, 1'b0, 12'h8B6});
    endtask

    task automatic alpha_levels();
        for (int k = 0; k < 4; k++) begin
            drive_pixel(8'd1, 8'(k), 1'b0, 1'b0, 1'b1);
        end
        drain_pipe();
    endtask

    // A index 3 has mix set, so ext must still win there
    task automatic arith_and_mix();
        for (int a = 2; a < 4; a++) begin
            for (int k = 4; k < 8; k++) begin
                drive_pixel(8'(a), 8'(k), 1'b0, 1'b0, 1'b1);
            end
        end
        drive_pixel(8'd3, 8'd8, 1'b0, 1'b0, 1'b1);
        drive_pixel(8'd2, 8'd8, 1'b0, 1'b0, 1'b1);
        drain_pipe();
    endtask

    task automatic sync_blanking();
        logic [7:0] ia;
        logic [7:0] ib;
        logic [2:0] s;
        for (int i = 0; i < 40; i++) begin
            ia = 8'd1 + 8'(rand_bits(1));
            ib = 8'(rand_bits(3));
            s  = 3'(rand_bits(3));
            drive_pixel(ia, ib, s[2], s[1], s[0]);
        end
        drain_pipe();
    endtask

    task automatic random_stream();
        logic [7:0] ia;
        logic [7:0] ib;
        for (int i = 0; i < 256; i++) begin
            write_lut(LUT_A, 8'(i), rand_bits(16));
            write_lut(LUT_B, 8'(i), rand_bits(16));
        end
        for (int i = 0; i < 200; i++) begin
            ia = 8'(rand_bits(8));
            ib = 8'(rand_bits(8));
            drive_pixel(ia, ib, lfsr_step(), lfsr_step(), 1'b1);
        end
        drain_pipe();
    endtask

    initial begin
        cycle_cnt = 0;
        rst_n     = 1'b0;
        lut_req   = 1'b0;
        lut_sel   = 1'b0;
        lut_addr  = '0;
        lut_data  = '0;
        pf_a_idx  = '0;
        pf_b_idx  = '0;
        hsync     = 1'b0;
        vsync     = 1'b0;
        dv_de     = 1'b0;
        reset_values();
        load_entries();
        alpha_levels();
        arith_and_mix();
        sync_blanking();
        random_stream();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
hw/vid_pkg.sv
hw/lut_wr_if.sv
hw/lut_write_port.sv
hw/color_lut.sv
hw/video_blend.sv
hw/video_out_top.sv
test/tb_video_out.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_video_out -f vlog.f -o tb_video_out_sim
./obj_dir/tb_video_out_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
